//--- run.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module memStageTb \
    -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/VmemStageTb > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

//--- source/dataRam.sv
/*
 * Tightly coupled data RAM for the memory stage.
 * Driven straight from the execute-side signals: checks alignment,
 * builds byte strobes and writes the word array on the edge that
 * moves the instruction into MEM. Read data and the alignment fault
 * are registered on the same edge and used during the MEM cycle.
 */
module dataRam
    import memPkg::*;
#(
    parameter int ramAddrBits = 10
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  logic        flushEx,
    input  logic        exValid,
    input  logic [31:0] exAluOut,
    input  logic [31:0] exOutB,
    input  loadTypeE    exLoadType,
    input  storeTypeE   exStoreType,
    input  excCodeE     exExcCode,
    output logic [31:0] memRdata,
    output excCodeE     memFault
);

    logic [31:0]            ram [2**ramAddrBits];
    logic [ramAddrBits-1:0] wordAddr;
    logic [3:0]             byteEn;
    logic [31:0]            wdata;
    logic                   ramWe;
    excCodeE                faultNow;

    assign wordAddr = exAluOut[ramAddrBits+1:2];

    always_comb begin
        faultNow = excNone;
        byteEn   = 4'b0000;
        wdata    = exOutB;
        case (exLoadType)
            loadLh, loadLhu: faultNow = exAluOut[0] ? excAdel : excNone;
            loadLw:          faultNow = (exAluOut[1:0] != 2'b00) ? excAdel : excNone;
            default: ;
        endcase
        case (exStoreType)
            storeSb: begin
                byteEn = 4'b0001 << exAluOut[1:0];
                wdata  = {4{exOutB[7:0]}};      // byte lane replicated
            end
            storeSh: begin
                byteEn   = exAluOut[1] ? 4'b1100 : 4'b0011;
                wdata    = {2{exOutB[15:0]}};
                faultNow = exAluOut[0] ? excAdes : excNone;
            end
            storeSw: begin
                byteEn   = 4'b1111;
                faultNow = (exAluOut[1:0] != 2'b00) ? excAdes : excNone;
            end
            default: ;
        endcase
    end

    // no write for a bubble, a fault, a carried exception or a trap in MEM
    assign ramWe = exValid && !stall && !flushEx && (exStoreType != storeNone)
                   && (faultNow == excNone) && (exExcCode == excNone);

    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int b = 0; b < 4; b++) begin
                if (ramWe && byteEn[b]) begin
                    ram[wordAddr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            memRdata <= ram[wordAddr];  // old word on a same-cycle write
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memFault <= excNone;
        end else if (!stall) begin
            memFault <= exValid ? faultNow : excNone;
        end
    end

    // halfword and word writes only go out on a naturally aligned address
    assert property (@(posedge clk) disable iff (!rstN)
        ramWe |-> !((exStoreType == storeSh && exAluOut[0])
                    || (exStoreType == storeSw && exAluOut[1:0] != 2'b00)))
        else $error("RAM written by a misaligned access");

endmodule

//--- source/exceptionUnit.sv
/*
 * Exception and interrupt resolution for the instruction in MEM.
 * Chooses one cause by priority: interrupt, then the code carried
 * from earlier stages, then the alignment fault from the RAM.
 * A trap or an eret raises all flush pulses, reports EPC and
 * BadVAddr, and cancels the register write of the instruction.
 */
module exceptionUnit
    import memPkg::*;
(
    input  logic        memValid,
    input  logic [31:0] memPc,
    input  logic [31:0] memAluOut,
    input  storeTypeE   memStoreType,
    input  logic        memRegWr,
    input  excCodeE     memExcCode,
    input  excCodeE     memFault,
    input  logic [31:0] cp0Status,
    input  logic [31:0] cp0Cause,
    output logic        flushId,
    output logic        flushEx,
    output logic        flushMem,
    output excKindE     excKind,
    output excCodeE     excCode,
    output logic [31:0] epc,
    output logic [31:0] badVAddr,
    output excCodeE     memExcCodeFinal,
    output logic        memRegWrFinal
);

    logic [imHigh-imLow:0] imMasked;
    logic                  intTaken;
    logic                  flush;
    excCodeE               code;

    assign imMasked = cp0Status[imHigh:imLow] & cp0Cause[imHigh:imLow];

    // stores have already written the RAM, so they are not interrupted
    assign intTaken = cp0Status[statusIeBit] && !cp0Status[statusExlBit]
                      && (imMasked != '0) && (memStoreType == storeNone);

    always_comb begin
        code = excNone;
        if (memValid) begin
            if (intTaken) begin
                code = excInt;
            end else if (memExcCode != excNone) begin
                code = memExcCode;              // decode / execute cause
            end else begin
                code = memFault;                // alignment, may be none
            end
        end
    end

    always_comb begin
        case (code)
            excNone: excKind = kindNone;
            excEret: excKind = kindEret;
            default: excKind = kindExc;
        endcase
    end

    assign flush    = (excKind != kindNone);
    assign flushId  = flush;
    assign flushEx  = flush;
    assign flushMem = flush;

    assign excCode         = code;
    assign memExcCodeFinal = code;

    assign epc      = flush ? memPc : 32'h0;
    assign badVAddr = (code == excAdel || code == excAdes) ? memAluOut : 32'h0;

    // trapped instructions retire without a register write
    assign memRegWrFinal = memValid && memRegWr && !flush;

    // flush pulses always travel together and belong to a live instruction
    always_comb begin
        if (flushId || flushEx || flushMem) begin
            assert (flushId && flushEx && flushMem && memValid)
                else $error("flush raised without a valid instruction in MEM");
        end
    end

endmodule

//--- source/loadAlign.sv
/*
 * Load alignment, bypass value and MEM/WB register.
 * Extracts the byte or halfword lane of the registered RAM word and
 * extends it by load type. fwdData is the MEM-stage result for
 * bypassing; the write-back record is registered on advancing edges.
 */
module loadAlign
    import memPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  logic        memValid,
    input  logic [31:0] memAluOut,
    input  logic [31:0] memOutB,
    input  loadTypeE    memLoadType,
    input  logic [4:0]  memDst,
    input  wbSelE       memWbSel,
    input  logic [31:0] memRdata,
    input  logic        memRegWrFinal,
    input  excCodeE     memExcCodeFinal,
    output logic [31:0] fwdData,
    output logic        wbValid,
    output logic        wbRegWr,
    output logic [4:0]  wbDst,
    output logic [31:0] wbData
);

    logic [7:0]  laneByte;
    logic [15:0] laneHalf;
    logic [31:0] loadData;
    logic        useLoad;

    assign laneByte = memRdata[{memAluOut[1:0], 3'b000} +: 8];
    assign laneHalf = memAluOut[1] ? memRdata[31:16] : memRdata[15:0];

    always_comb begin
        case (memLoadType)
            loadLb:  loadData = {{24{laneByte[7]}}, laneByte};
            loadLbu: loadData = {24'h0, laneByte};
            loadLh:  loadData = {{16{laneHalf[15]}}, laneHalf};
            loadLhu: loadData = {16'h0, laneHalf};
            default: loadData = memRdata;       // lw
        endcase
    end

    // load data is not ready for bypass in MEM
    assign fwdData = (memWbSel == wbOutB) ? memOutB : memAluOut;

    // a trapped load keeps its address instead of RAM data
    assign useLoad = (memWbSel == wbMem) && (memExcCodeFinal == excNone);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
            wbRegWr <= 1'b0;
        end else if (!stall) begin
            wbValid <= memValid;
            wbRegWr <= memRegWrFinal;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wbDst  <= memDst;
            wbData <= useLoad ? loadData : fwdData;
        end
    end

endmodule

//--- source/memPkg.sv
/*
 * Shared types for the memory stage of the integer pipeline.
 * Holds the load, store and write-back encodings, the cause codes
 * that the stage can raise and the CP0 field positions it reads.
 * Modules take it with a wildcard import in their header.
 */
package memPkg;

    // load kind carried from decode
    typedef enum logic [2:0] {
        loadNone,
        loadLb,
        loadLbu,
        loadLh,
        loadLhu,
        loadLw
    } loadTypeE;

    // store kind, also selects the byte strobes
    typedef enum logic [1:0] {
        storeNone,
        storeSb,
        storeSh,
        storeSw
    } storeTypeE;

    typedef enum logic [1:0] {
        wbAlu,                  // alu result
        wbMem,                  // aligned load data
        wbOutB                  // second operand, for moves
    } wbSelE;

    // MIPS cause codes; none and eret sit outside the architected range
    typedef enum logic [4:0] {
        excInt   = 5'd0,
        excAdel  = 5'd4,
        excAdes  = 5'd5,
        excSys   = 5'd8,
        excBp    = 5'd9,
        excRi    = 5'd10,
        excOv    = 5'd12,
        excEret  = 5'd30,       // pseudo code, never written to Cause
        excNone  = 5'd31
    } excCodeE;

    typedef enum logic [1:0] {
        kindNone,
        kindExc,
        kindEret
    } excKindE;

    // CP0 Status / Cause bit positions
    localparam int statusIeBit  = 0;
    localparam int statusExlBit = 1;
    localparam int imLow        = 8;    // IM in Status, IP in Cause
    localparam int imHigh       = 15;

endpackage

//--- source/memStageReg.sv
/*
 * EX/MEM pipeline register.
 * Captures the execute-side fields on every edge where stall is low
 * and holds them otherwise. The memFlush level or the exception flush
 * turns the captured slot into a bubble.
 */
module memStageReg
    import memPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  logic        memFlush,
    input  logic        flushMem,
    input  logic        exValid,
    input  logic [31:0] exPc,
    input  logic [31:0] exAluOut,
    input  logic [31:0] exOutB,
    input  loadTypeE    exLoadType,
    input  storeTypeE   exStoreType,
    input  logic [4:0]  exDst,
    input  logic        exRegWr,
    input  wbSelE       exWbSel,
    input  excCodeE     exExcCode,
    output logic        memValid,
    output logic [31:0] memPc,
    output logic [31:0] memAluOut,
    output logic [31:0] memOutB,
    output loadTypeE    memLoadType,
    output storeTypeE   memStoreType,
    output logic [4:0]  memDst,
    output logic        memRegWr,
    output wbSelE       memWbSel,
    output excCodeE     memExcCode
);

    logic toBubble;

    assign toBubble = memFlush || flushMem;

    // control fields, cleared on reset and on a bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memValid     <= 1'b0;
            memRegWr     <= 1'b0;
            memLoadType  <= loadNone;
            memStoreType <= storeNone;
            memExcCode   <= excNone;
        end else if (!stall) begin
            memValid     <= exValid && !toBubble;
            memRegWr     <= exRegWr && !toBubble;
            memLoadType  <= toBubble ? loadNone : exLoadType;
            memStoreType <= toBubble ? storeNone : exStoreType;
            memExcCode   <= toBubble ? excNone : exExcCode;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            memPc     <= exPc;
            memAluOut <= exAluOut;
            memOutB   <= exOutB;
            memDst    <= exDst;
            memWbSel  <= exWbSel;
        end
    end

    // a new instruction only enters on an advancing edge
    assert property (@(posedge clk) disable iff (!rstN) $rose(memValid) |-> !$past(stall))
        else $error("memValid rose after a stalled edge");

endmodule

//--- source/memStageTop.sv
/*
 * Memory stage of the five-stage pipeline.
 * Takes the execute-side record of each instruction, accesses the data
 * RAM, resolves exceptions in MEM and registers the write-back record.
 * ramAddrBits sets the RAM depth in words as a power of two.
 */
module memStageTop
    import memPkg::*;
#(
    parameter int ramAddrBits = 10
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        exValid,
    input  logic [31:0] exPc,
    input  logic [31:0] exAluOut,
    input  logic [31:0] exOutB,
    input  loadTypeE    exLoadType,
    input  storeTypeE   exStoreType,
    input  logic [4:0]  exDst,
    input  logic        exRegWr,
    input  wbSelE       exWbSel,
    input  excCodeE     exExcCode,
    input  logic        stall,
    input  logic        memFlush,
    input  logic [31:0] cp0Status,
    input  logic [31:0] cp0Cause,
    output logic        flushId,
    output logic        flushEx,
    output logic        flushMem,
    output excKindE     excKind,
    output excCodeE     excCode,
    output logic [31:0] epc,
    output logic [31:0] badVAddr,
    output logic [31:0] fwdData,
    output logic [4:0]  memDst,
    output logic        memRegWrFinal,
    output logic        wbValid,
    output logic [4:0]  wbDst,
    output logic [31:0] wbData,
    output logic        wbRegWr
);

    logic        memValid;
    logic [31:0] memPc;
    logic [31:0] memAluOut;
    logic [31:0] memOutB;
    loadTypeE    memLoadType;
    storeTypeE   memStoreType;
    logic        memRegWr;
    wbSelE       memWbSel;
    excCodeE     memExcCode;
    logic [31:0] memRdata;
    excCodeE     memFault;          // alignment cause, registered beside read data
    excCodeE     memExcCodeFinal;

    memStageReg memStageReg_i (
        .clk          (clk),
        .rstN         (rstN),
        .stall        (stall),
        .memFlush     (memFlush),
        .flushMem     (flushMem),
        .exValid      (exValid),
        .exPc         (exPc),
        .exAluOut     (exAluOut),
        .exOutB       (exOutB),
        .exLoadType   (exLoadType),
        .exStoreType  (exStoreType),
        .exDst        (exDst),
        .exRegWr      (exRegWr),
        .exWbSel      (exWbSel),
        .exExcCode    (exExcCode),
        .memValid     (memValid),
        .memPc        (memPc),
        .memAluOut    (memAluOut),
        .memOutB      (memOutB),
        .memLoadType  (memLoadType),
        .memStoreType (memStoreType),
        .memDst       (memDst),
        .memRegWr     (memRegWr),
        .memWbSel     (memWbSel),
        .memExcCode   (memExcCode)
    );

    // request built from EX-side values, data back in MEM
    dataRam #(
        .ramAddrBits (ramAddrBits)
    ) dataRam_i (
        .clk         (clk),
        .rstN        (rstN),
        .stall       (stall),
        .flushEx     (flushEx),
        .exValid     (exValid),
        .exAluOut    (exAluOut),
        .exOutB      (exOutB),
        .exLoadType  (exLoadType),
        .exStoreType (exStoreType),
        .exExcCode   (exExcCode),
        .memRdata    (memRdata),
        .memFault    (memFault)
    );

    exceptionUnit exceptionUnit_i (
        .memValid        (memValid),
        .memPc           (memPc),
        .memAluOut       (memAluOut),
        .memStoreType    (memStoreType),
        .memRegWr        (memRegWr),
        .memExcCode      (memExcCode),
        .memFault        (memFault),
        .cp0Status       (cp0Status),
        .cp0Cause        (cp0Cause),
        .flushId         (flushId),
        .flushEx         (flushEx),
        .flushMem        (flushMem),
        .excKind         (excKind),
        .excCode         (excCode),
        .epc             (epc),
        .badVAddr        (badVAddr),
        .memExcCodeFinal (memExcCodeFinal),
        .memRegWrFinal   (memRegWrFinal)
    );

    loadAlign loadAlign_i (
        .clk             (clk),
        .rstN            (rstN),
        .stall           (stall),
        .memValid        (memValid),
        .memAluOut       (memAluOut),
        .memOutB         (memOutB),
        .memLoadType     (memLoadType),
        .memDst          (memDst),
        .memWbSel        (memWbSel),
        .memRdata        (memRdata),
        .memRegWrFinal   (memRegWrFinal),
        .memExcCodeFinal (memExcCodeFinal),
        .fwdData         (fwdData),
        .wbValid         (wbValid),
        .wbRegWr         (wbRegWr),
        .wbDst           (wbDst),
        .wbData          (wbData)
    );

endmodule

//--- tb/memStageChecker.sv
/*
 * Output checker for the memory stage.
 * The testbench pushes one MEM-cycle prediction per clock and one
 * write-back prediction per retiring instruction. Ports are sampled
 * 10 ns after each falling edge and compared in order.
 */
module memStageChecker
    import memPkg::*;
(
    input  logic        clk,
    input  logic        stall,
    input  logic        flushId,
    input  logic        flushEx,
    input  logic        flushMem,
    input  excKindE     excKind,
    input  excCodeE     excCode,
    input  logic [31:0] epc,
    input  logic [31:0] badVAddr,
    input  logic [31:0] fwdData,
    input  logic [4:0]  memDst,
    input  logic        memRegWrFinal,
    input  logic        wbValid,
    input  logic [4:0]  wbDst,
    input  logic [31:0] wbData,
    input  logic        wbRegWr,
    output int          errCount
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [1:0]  kindQ[$];
    logic [4:0]  codeQ[$];
    logic [31:0] epcQ[$];
    logic [31:0] badQ[$];
    logic [31:0] fwdQ[$];
    logic        fwdOnQ[$];
    logic [4:0]  memDstQ[$];
    logic        memWrQ[$];
    logic [4:0]  dstQ[$];
    logic [31:0] dataQ[$];
    logic        wrQ[$];
    logic        lastStall = 1'b0;     // stall applied at the edge just passed

    initial errCount = 0;

    task automatic pushCycle(input logic [1:0] kind, input logic [4:0] code,
                             input logic [31:0] epcE, input logic [31:0] badE,
                             input logic [31:0] fwdE, input logic fwdOn,
                             input logic [4:0] dstE, input logic wrE);
        kindQ.push_back(kind);
        codeQ.push_back(code);
        epcQ.push_back(epcE);
        badQ.push_back(badE);
        fwdQ.push_back(fwdE);
        fwdOnQ.push_back(fwdOn);
        memDstQ.push_back(dstE);
        memWrQ.push_back(wrE);
    endtask

    task automatic pushWb(input logic [4:0] dst, input logic [31:0] data, input logic wr);
        dstQ.push_back(dst);
        dataQ.push_back(data);
        wrQ.push_back(wr);
    endtask

    task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
        errCount++;
        $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    // leftovers mean the DUT dropped records
    task automatic finalCheck();
        if (dstQ.size() != 0) begin
            errCount++;
            $display("missing write-back records: %0d never appeared", dstQ.size());
        end
        if (kindQ.size() != 0) begin
            errCount++;
            $display("MEM-cycle predictions left unchecked: %0d", kindQ.size());
        end
    endtask

    always @(negedge clk) begin
        logic        fwdOn;
        logic [31:0] expFwd;
        logic [4:0]  expMemDst;
        logic        expMemWr;
        logic        expFlush;
        logic        expWr;
        #10;
        if (kindQ.size() != 0) begin
            fwdOn     = fwdOnQ.pop_front();
            expFwd    = fwdQ.pop_front();
            expMemDst = memDstQ.pop_front();
            expMemWr  = memWrQ.pop_front();
            expFlush  = (kindQ[0] != 2'd0);     // trap or eret flushes every stage
            if (excKind !== kindQ[0])  mismatch("excKind", 32'(excKind), 32'(kindQ[0]));
            if (excCode !== codeQ[0])  mismatch("excCode", 32'(excCode), 32'(codeQ[0]));
            if (epc !== epcQ[0])       mismatch("epc", epc, epcQ[0]);
            if (badVAddr !== badQ[0])  mismatch("badVAddr", badVAddr, badQ[0]);
            if (flushId !== expFlush)  mismatch("flushId", 32'(flushId), 32'(expFlush));
            if (flushEx !== expFlush)  mismatch("flushEx", 32'(flushEx), 32'(expFlush));
            if (flushMem !== expFlush) mismatch("flushMem", 32'(flushMem), 32'(expFlush));
            if (fwdOn && fwdData !== expFwd) mismatch("fwdData", fwdData, expFwd);
            if (fwdOn && memDst !== expMemDst) begin
                mismatch("memDst", 32'(memDst), 32'(expMemDst));
            end
            if (memRegWrFinal !== expMemWr) begin
                mismatch("memRegWrFinal", 32'(memRegWrFinal), 32'(expMemWr));
            end
            void'(kindQ.pop_front());
            void'(codeQ.pop_front());
            void'(epcQ.pop_front());
            void'(badQ.pop_front());
        end
        // a record held through a stalled edge is still the same record
        if (wbValid === 1'b1 && !lastStall) begin
            if (dstQ.size() == 0) begin
                errCount++;
                $display("extra write-back record at time %0t with no instruction behind it",
                         $time);
            end else begin
                expWr = wrQ.pop_front();
                if (wbDst !== dstQ[0])   mismatch("wbDst", 32'(wbDst), 32'(dstQ[0]));
                if (wbRegWr !== expWr)   mismatch("wbRegWr", 32'(wbRegWr), 32'(expWr));
                if (expWr && wbData !== dataQ[0]) mismatch("wbData", wbData, dataQ[0]);
                void'(dstQ.pop_front());
                void'(dataQ.pop_front());
            end
        end
        lastStall = stall;
    end

endmodule

//--- tb/memStageTb.sv
/*
 * Testbench top for the memory stage.
 * Fills a 16-word window of the RAM, then drives random loads, stores,
 * ALU ops, carried exceptions, stalls, flushes and interrupts. A model
 * runs on each falling edge and feeds predictions to the checker.
 */
module memStageTb
    import memPkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int initOps     = 16;
    localparam int randOps     = 600;
    localparam int drainCycles = 10;
    localparam int cycleLimit  = 2 * (initOps + randOps + drainCycles) + 100;

    logic clk, rstN;
    logic exValid, exRegWr, stall, memFlush;
    logic [31:0] exPc, exAluOut, exOutB, cp0Status, cp0Cause;
    loadTypeE exLoadType;
    storeTypeE exStoreType;
    logic [4:0] exDst;
    wbSelE exWbSel;
    excCodeE exExcCode;
    logic flushId, flushEx, flushMem, memRegWrFinal, wbValid, wbRegWr;
    excKindE excKind;
    excCodeE excCode;
    logic [31:0] epc, badVAddr, fwdData, wbData;
    logic [4:0] memDst, wbDst;
    int errCount;
    int cycles = 0;
    logic [31:0] seed = 32'd61;

    // model state: the instruction in MEM and a copy of the RAM window
    logic        sValid = 1'b0, sRegWr;
    logic [31:0] sPc, sAlu, sOutB, sRdata;
    loadTypeE    sLoad;
    storeTypeE   sStore = storeNone;
    logic [4:0]  sDst, sFault;
    wbSelE       sWbSel;
    excCodeE     sExc = excNone;
    logic [31:0] refRam [16];

    tbClock #(.periodNs(100), .resetCycles(8)) tbClock_i (.clk(clk), .rstN(rstN));

    memStageTop #(.ramAddrBits(10)) memStageTop_i (.*);

    memStageChecker checker_i (
        .clk(clk), .stall(stall), .flushId(flushId), .flushEx(flushEx), .flushMem(flushMem),
        .excKind(excKind), .excCode(excCode), .epc(epc), .badVAddr(badVAddr),
        .fwdData(fwdData), .memDst(memDst), .memRegWrFinal(memRegWrFinal),
        .wbValid(wbValid), .wbDst(wbDst), .wbData(wbData), .wbRegWr(wbRegWr),
        .errCount(errCount)
    );

    function automatic logic [31:0] nextRand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic void memStageModel(
        output logic [1:0] kindE, output logic [4:0] codeE, output logic [31:0] epcE,
        output logic [31:0] badE, output logic [31:0] fwdE, output logic retire,
        output logic [4:0] dstE, output logic [31:0] dataE, output logic wrE);
        logic [7:0]  pend;
        logic        trap;
        logic [7:0]  lane8;
        logic [15:0] lane16;
        logic [31:0] loadV;
        logic [4:0]  exFault;
        logic [3:0]  idx;
        logic [31:0] word;
        pend  = cp0Status[15:8] & cp0Cause[15:8];
        codeE = excNone;
        if (sValid) begin
            if (cp0Status[0] && !cp0Status[1] && pend != 8'h0 && sStore == storeNone)
                codeE = excInt;
            else if (sExc != excNone)
                codeE = sExc;
            else
                codeE = sFault;
        end
        kindE = (codeE == excNone) ? 2'd0 : (codeE == excEret) ? 2'd2 : 2'd1;
        trap  = (kindE != 2'd0);
        epcE  = trap ? sPc : 32'h0;
        badE  = (codeE == excAdel || codeE == excAdes) ? sAlu : 32'h0;
        fwdE  = (sWbSel == wbOutB) ? sOutB : sAlu;
        lane8  = sRdata[8*sAlu[1:0] +: 8];
        lane16 = sAlu[1] ? sRdata[31:16] : sRdata[15:0];
        case (sLoad)
            loadLb:  loadV = {{24{lane8[7]}}, lane8};
            loadLbu: loadV = {24'h0, lane8};
            loadLh:  loadV = {{16{lane16[15]}}, lane16};
            loadLhu: loadV = {16'h0, lane16};
            default: loadV = sRdata;
        endcase
        dataE  = (sWbSel == wbMem && codeE == excNone) ? loadV : fwdE;
        wrE    = sValid && sRegWr && !trap;
        dstE   = sDst;
        retire = sValid && !stall;
        if (!stall) begin
            exFault = excNone;
            if ((exLoadType == loadLh || exLoadType == loadLhu) && exAluOut[0]) exFault = excAdel;
            if (exLoadType == loadLw && exAluOut[1:0] != 2'b00) exFault = excAdel;
            if (exStoreType == storeSh && exAluOut[0]) exFault = excAdes;
            if (exStoreType == storeSw && exAluOut[1:0] != 2'b00) exFault = excAdes;
            idx  = exAluOut[5:2];
            word = refRam[idx];
            sRdata = word;      // read sees the word before this edge's store
            if (exValid && !trap && exStoreType != storeNone && exFault == excNone
                    && exExcCode == excNone) begin
                case (exStoreType)
                    storeSb: word[8*exAluOut[1:0] +: 8] = exOutB[7:0];
                    storeSh: word[16*exAluOut[1] +: 16] = exOutB[15:0];
                    default: word = exOutB;
                endcase
                refRam[idx] = word;
            end
            sFault = exValid ? exFault : excNone;
            sValid = exValid && !memFlush && !trap;
            sPc = exPc;
            sAlu = exAluOut;
            sOutB = exOutB;
            sLoad = exLoadType;
            sStore = exStoreType;
            sDst = exDst;
            sRegWr = exRegWr;
            sWbSel = exWbSel;
            sExc = exExcCode;
        end
    endfunction

    // one slot of a random op, address kept inside the 16-word window
    task automatic randomOp(input int n);
        logic [31:0] r;
        logic [1:0]  low;
        r = nextRand();
        low = 2'(nextRand());
        exValid = (nextRand() % 8) != 0;
        exPc = 32'h400 + 32'(n) * 4;
        exAluOut = nextRand();
        exOutB = nextRand();
        exDst = 5'(nextRand());
        exRegWr = 1'b1;
        exLoadType = loadNone;
        exStoreType = storeNone;
        exWbSel = wbAlu;
        exExcCode = excNone;
        if ((nextRand() % 4) != 0) low = 2'b00;     // mostly aligned
        if (r % 12 < 8) exAluOut = 32'h100 | (nextRand() & 32'h3c) | 32'(low);
        case (r % 12)
            0: begin exStoreType = storeSb; exRegWr = 1'b0; end
            1: begin exStoreType = storeSh; exRegWr = 1'b0; end
            2: begin exStoreType = storeSw; exRegWr = 1'b0; end
            3: begin exLoadType = loadLb; exWbSel = wbMem; end
            4: begin exLoadType = loadLbu; exWbSel = wbMem; end
            5: begin exLoadType = loadLh; exWbSel = wbMem; end
            6: begin exLoadType = loadLhu; exWbSel = wbMem; end
            7: begin exLoadType = loadLw; exWbSel = wbMem; end
            8: exWbSel = wbOutB;
            9: begin
                case (nextRand() % 5)
                    0: exExcCode = excOv;
                    1: exExcCode = excSys;
                    2: exExcCode = excBp;
                    3: exExcCode = excRi;
                    default: exExcCode = excEret;
                endcase
            end
            default: ;
        endcase
        stall = (nextRand() % 6) == 0;
        memFlush = (nextRand() % 16) == 0;
        cp0Status = {16'h0, 8'(nextRand()), 6'h0, (nextRand() % 4) == 0, 1'b1};
        cp0Cause = ((nextRand() % 8) == 0) ? (32'h100 << (nextRand() % 8)) : 32'h0;
    endtask

    task automatic quietSlot();
        exValid = 1'b0;
        exLoadType = loadNone;
        exStoreType = storeNone;
        exExcCode = excNone;
        stall = 1'b0;
        memFlush = 1'b0;
        cp0Status = 32'h0;
        cp0Cause = 32'h0;
    endtask

    always @(negedge clk) begin
        logic [1:0] kindE;
        logic [4:0] codeE, dstE;
        logic [31:0] epcE, badE, fwdE, dataE;
        logic retire, wrE, fwdOn;
        if (rstN) begin
            fwdOn = sValid;
            memStageModel(kindE, codeE, epcE, badE, fwdE, retire, dstE, dataE, wrE);
            checker_i.pushCycle(kindE, codeE, epcE, badE, fwdE, fwdOn, dstE, wrE);
            if (retire) checker_i.pushWb(dstE, dataE, wrE);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("errors: %0d", errCount + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        exPc = 32'h0;
        exAluOut = 32'h0;
        exOutB = 32'h0;
        exDst = 5'd0;
        exRegWr = 1'b0;
        exWbSel = wbAlu;
        quietSlot();
        wait (rstN === 1'b1);
        for (int i = 0; i < initOps; i++) begin     // fill the RAM window
            @(posedge clk);
            #10;
            quietSlot();
            exValid = 1'b1;
            exPc = 32'h300 + 32'(i) * 4;
            exAluOut = 32'h100 + 32'(i) * 4;
            exOutB = nextRand();
            exStoreType = storeSw;
            exRegWr = 1'b0;
            exWbSel = wbAlu;
        end
        for (int i = 0; i < randOps; i++) begin
            @(posedge clk);
            #10;
            randomOp(i);
        end
        for (int i = 0; i < drainCycles; i++) begin
            @(posedge clk);
            #10;
            quietSlot();
        end
        @(negedge clk);
        #20;
        checker_i.finalCheck();
        $display("errors: %0d", errCount);
        if (errCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tb/tbClock.sv
/*
 * Clock and reset source for the memory stage testbench.
 * Free-running clock of the given period; rstN is held low for
 * resetCycles rising edges and released shortly after the last one.
 */
module tbClock #(
    parameter int periodNs    = 100,
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk  = 1'b0;
        rstN = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    initial begin
        repeat (resetCycles) @(posedge clk);
        #20 rstN = 1'b1;        // away from both clock edges
    end

endmodule

//--- vlog.f
source/memPkg.sv
source/memStageReg.sv
source/dataRam.sv
source/exceptionUnit.sv
source/loadAlign.sv
source/memStageTop.sv
tb/tbClock.sv
tb/memStageChecker.sv
tb/memStageTb.sv
